// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_isu
FILELIST  ?= files.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: busy_table.sv
`timescale 1ns/1ps
`default_nettype none

module busy_table (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic [isu_pkg::PREG_W-1:0] bt_rs1,
    input  logic [isu_pkg::PREG_W-1:0] bt_rs2,
    output logic                       src1_busy,
    output logic                       src2_busy,
    input  logic                       bt_alloc_en,
    input  logic [isu_pkg::PREG_W-1:0] bt_alloc_prd,
    input  isu_pkg::wb_t               wb
);
    logic [isu_pkg::PREG_COUNT-1:0] busy;
    logic                           wb_free;

    assign wb_free = wb.valid && wb.need_to_wb;

    // a register written back this cycle already counts as ready
    assign src1_busy = busy[bt_rs1] && !(wb_free && (wb.prd == bt_rs1));
    assign src2_busy = busy[bt_rs2] && !(wb_free && (wb.prd == bt_rs2));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy <= '0;
        end else begin
            if (wb_free) begin
                busy[wb.prd] <= 1'b0;
            end
            if (bt_alloc_en) begin
                busy[bt_alloc_prd] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         in_valid,
    input  isu_pkg::uop_t                in_uop,
    output logic                         in_ready,
    input  logic                         rob_can_enq,
    input  logic [isu_pkg::ROB_ID_W-1:0] alloc_robid,
    output logic                         rob_enq_valid,
    output isu_pkg::rob_entry_t          rob_enq_entry,
    input  logic                         iq_can_enq,
    output logic                         iq_enq_valid,
    output isu_pkg::iq_entry_t           iq_enq_entry,
    output logic [isu_pkg::PREG_W-1:0]   bt_rs1,
    output logic [isu_pkg::PREG_W-1:0]   bt_rs2,
    input  logic                         src1_busy,
    input  logic                         src2_busy,
    output logic                         bt_alloc_en,
    output logic [isu_pkg::PREG_W-1:0]   bt_alloc_prd
);
    logic fire;
    logic pend_hit1;
    logic pend_hit2;

    assign in_ready      = rob_can_enq && iq_can_enq;
    assign fire          = in_valid && in_ready;
    assign rob_enq_valid = fire;
    assign iq_enq_valid  = fire;

    assign bt_rs1 = in_uop.prs1;
    assign bt_rs2 = in_uop.prs2;

    // the busy bit lands one edge after acceptance,
    // so the micro-op right behind its producer is caught here
    assign pend_hit1 = bt_alloc_en && (bt_alloc_prd == in_uop.prs1);
    assign pend_hit2 = bt_alloc_en && (bt_alloc_prd == in_uop.prs2);

    always_comb begin
        rob_enq_entry.pc         = in_uop.pc;
        rob_enq_entry.instr      = in_uop.instr;
        rob_enq_entry.lrd        = in_uop.lrd;
        rob_enq_entry.prd        = in_uop.prd;
        rob_enq_entry.old_prd    = in_uop.old_prd;
        rob_enq_entry.need_to_wb = in_uop.need_to_wb;
    end

    // immediates and constant sources start out ready
    always_comb begin
        iq_enq_entry.uop        = in_uop;
        iq_enq_entry.robid      = alloc_robid;
        iq_enq_entry.src1_ready = !in_uop.src1_is_reg || !(src1_busy || pend_hit1);
        iq_enq_entry.src2_ready = !in_uop.src2_is_reg || !(src2_busy || pend_hit2);
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            bt_alloc_en <= 1'b0;
        end else begin
            bt_alloc_en <= fire && in_uop.need_to_wb;
        end
    end

    always_ff @(posedge clock) begin
        if (fire) begin
            bt_alloc_prd <= in_uop.prd;
        end
    end

endmodule

`default_nettype wire

// File: files.f
isu_pkg.sv
busy_table.sv
preg_file.sv
rob.sv
issue_queue.sv
dispatch.sv
isu_top.sv
isu_asserts.sv
tb_isu.sv

// File: issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       iq_enq_valid,
    input  isu_pkg::iq_entry_t         iq_enq_entry,
    output logic                       iq_can_enq,
    input  isu_pkg::wb_t               wb,
    output logic [isu_pkg::PREG_W-1:0] raddr1,
    output logic [isu_pkg::PREG_W-1:0] raddr2,
    input  logic [isu_pkg::XLEN-1:0]   rdata1,
    input  logic [isu_pkg::XLEN-1:0]   rdata2,
    output logic                       issue_valid,
    input  logic                       issue_ready,
    output isu_pkg::issue_t            issue_uop
);
    // slot 0 holds the oldest entry, the queue collapses on each issue
    isu_pkg::iq_entry_t ent     [isu_pkg::IQ_DEPTH];
    isu_pkg::iq_entry_t woke    [isu_pkg::IQ_DEPTH];
    isu_pkg::iq_entry_t shifted [isu_pkg::IQ_DEPTH];
    isu_pkg::iq_entry_t sel_ent;

    logic [isu_pkg::IQ_IDX_W:0]   count;
    logic [isu_pkg::IQ_IDX_W:0]   enq_slot;
    logic [isu_pkg::IQ_IDX_W-1:0] sel_idx;
    logic [isu_pkg::IQ_DEPTH-1:0] rdy;
    logic                         sel_any;
    logic                         sel_fire;
    logic                         enq_fire;
    logic                         wake;

    assign wake       = wb.valid && wb.need_to_wb;
    assign iq_can_enq = (count != (isu_pkg::IQ_IDX_W + 1)'(isu_pkg::IQ_DEPTH));
    assign enq_fire   = iq_enq_valid && iq_can_enq;

    // wakeup on the writeback tag, readiness from the stored flags
    always_comb begin
        for (int i = 0; i < isu_pkg::IQ_DEPTH; i++) begin
            woke[i] = ent[i];
            if (wake && (ent[i].uop.prs1 == wb.prd)) begin
                woke[i].src1_ready = 1'b1;
            end
            if (wake && (ent[i].uop.prs2 == wb.prd)) begin
                woke[i].src2_ready = 1'b1;
            end
            rdy[i] = (i < count) && ent[i].src1_ready && ent[i].src2_ready;
        end
    end

    always_comb begin
        for (int i = 0; i < isu_pkg::IQ_DEPTH - 1; i++) begin
            shifted[i] = woke[i + 1];
        end
        shifted[isu_pkg::IQ_DEPTH - 1] = woke[isu_pkg::IQ_DEPTH - 1];
    end

    // lowest ready slot is the oldest
    always_comb begin
        sel_any = 1'b0;
        sel_idx = '0;
        for (int i = isu_pkg::IQ_DEPTH - 1; i >= 0; i--) begin
            if (rdy[i]) begin
                sel_any = 1'b1;
                sel_idx = (isu_pkg::IQ_IDX_W)'(i);
            end
        end
    end

    assign sel_ent  = ent[sel_idx];
    assign sel_fire = sel_any && (!issue_valid || issue_ready);
    assign raddr1   = sel_ent.uop.prs1;
    assign raddr2   = sel_ent.uop.prs2;
    assign enq_slot = count - (isu_pkg::IQ_IDX_W + 1)'(sel_fire);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else begin
            count <= enq_slot + (isu_pkg::IQ_IDX_W + 1)'(enq_fire);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < isu_pkg::IQ_DEPTH; i++) begin
            if (sel_fire && (i >= sel_idx)) begin
                ent[i] <= shifted[i];
            end else begin
                ent[i] <= woke[i];
            end
        end
        if (enq_fire) begin
            ent[enq_slot[isu_pkg::IQ_IDX_W-1:0]] <= iq_enq_entry;
        end
    end

    // issue register, held while the execution unit stalls
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            issue_valid <= 1'b0;
        end else if (sel_fire) begin
            issue_valid <= 1'b1;
        end else if (issue_ready) begin
            issue_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (sel_fire) begin
            issue_uop.uop   <= sel_ent.uop;
            issue_uop.robid <= sel_ent.robid;
            issue_uop.src1  <= sel_ent.uop.src1_is_reg ? rdata1 : '0;
            issue_uop.src2  <= sel_ent.uop.src2_is_reg ? rdata2 : '0;
        end
    end

endmodule

`default_nettype wire

// File: isu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module isu_asserts (
    input logic             clock,
    input logic             reset_n,
    input logic             issue_valid,
    input logic             issue_ready,
    input isu_pkg::issue_t  issue_uop,
    input isu_pkg::wb_t     wb,
    input isu_pkg::commit_t commit
);
    // a stalled issue keeps its payload
    assert property (@(posedge clock) disable iff (!reset_n)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue_uop))
        else $error("issue_uop not held during stall");

    // writeback of the head entry retires it on the next cycle
    assert property (@(posedge clock) disable iff (!reset_n)
        wb.valid && (wb.robid == commit.robid) |=> commit.valid)
        else $error("head writeback not followed by commit");

    // the micro-op in the issue register is still in flight in the ROB
    assert property (@(posedge clock) disable iff (!reset_n)
        issue_valid |-> (5'(issue_uop.robid - commit.robid) < 5'd16))
        else $error("issued robid outside the ROB window");

endmodule

bind isu_top isu_asserts i_asserts (
    .clock       (clock),
    .reset_n     (reset_n),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue_uop   (issue_uop),
    .wb          (wb),
    .commit      (commit)
);

`default_nettype wire

// File: isu_pkg.sv
`default_nettype none

package isu_pkg;

    localparam int PREG_COUNT = 64;
    localparam int PREG_W     = 6;
    localparam int LREG_W     = 5;
    localparam int XLEN       = 64;
    localparam int PC_W       = 64;
    localparam int INSTR_W    = 32;
    localparam int ALU_TYPE_W = 11;

    // robid is the entry index plus one wrap bit
    localparam int ROB_DEPTH  = 16;
    localparam int ROB_IDX_W  = 4;
    localparam int ROB_ID_W   = ROB_IDX_W + 1;

    localparam int IQ_DEPTH   = 8;
    localparam int IQ_IDX_W   = 3;

    typedef struct packed {
        logic [PC_W-1:0]       pc;
        logic [INSTR_W-1:0]    instr;
        logic [LREG_W-1:0]     lrd;
        logic [PREG_W-1:0]     prd;
        logic [PREG_W-1:0]     old_prd;
        logic                  need_to_wb;
        logic [PREG_W-1:0]     prs1;
        logic [PREG_W-1:0]     prs2;
        logic                  src1_is_reg;
        logic                  src2_is_reg;
        logic [XLEN-1:0]       imm;
        logic [ALU_TYPE_W-1:0] alu_type;
        logic                  is_word;
        logic                  is_unsigned;
        logic                  is_imm;
    } uop_t;

    typedef struct packed {
        logic [PC_W-1:0]    pc;
        logic [INSTR_W-1:0] instr;
        logic [LREG_W-1:0]  lrd;
        logic [PREG_W-1:0]  prd;
        logic [PREG_W-1:0]  old_prd;
        logic               need_to_wb;
    } rob_entry_t;

    typedef struct packed {
        uop_t                uop;
        logic [ROB_ID_W-1:0] robid;
        logic                src1_ready;
        logic                src2_ready;
    } iq_entry_t;

    typedef struct packed {
        uop_t                uop;
        logic [ROB_ID_W-1:0] robid;
        logic [XLEN-1:0]     src1;
        logic [XLEN-1:0]     src2;
    } issue_t;

    typedef struct packed {
        logic                valid;
        logic [ROB_ID_W-1:0] robid;
        logic                need_to_wb;
        logic [PREG_W-1:0]   prd;
        logic [XLEN-1:0]     result;
    } wb_t;

    typedef struct packed {
        logic                valid;
        logic [ROB_ID_W-1:0] robid;
        logic [PC_W-1:0]     pc;
        logic [INSTR_W-1:0]  instr;
        logic [LREG_W-1:0]   lrd;
        logic [PREG_W-1:0]   prd;
        logic [PREG_W-1:0]   old_prd;
        logic                need_to_wb;
    } commit_t;

endpackage

`default_nettype wire

// File: isu_top.sv
`timescale 1ns/1ps
`default_nettype none

module isu_top (
    input  logic             clock,
    input  logic             reset_n,
    input  logic             in_valid,
    input  isu_pkg::uop_t    in_uop,
    output logic             in_ready,
    output logic             issue_valid,
    input  logic             issue_ready,
    output isu_pkg::issue_t  issue_uop,
    input  isu_pkg::wb_t     wb,
    output isu_pkg::commit_t commit
);
    logic                         rob_can_enq;
    logic [isu_pkg::ROB_ID_W-1:0] alloc_robid;
    logic                         rob_enq_valid;
    isu_pkg::rob_entry_t          rob_enq_entry;
    logic                         iq_can_enq;
    logic                         iq_enq_valid;
    isu_pkg::iq_entry_t           iq_enq_entry;
    logic [isu_pkg::PREG_W-1:0]   bt_rs1;
    logic [isu_pkg::PREG_W-1:0]   bt_rs2;
    logic                         src1_busy;
    logic                         src2_busy;
    logic                         bt_alloc_en;
    logic [isu_pkg::PREG_W-1:0]   bt_alloc_prd;
    logic [isu_pkg::PREG_W-1:0]   raddr1;
    logic [isu_pkg::PREG_W-1:0]   raddr2;
    logic [isu_pkg::XLEN-1:0]     rdata1;
    logic [isu_pkg::XLEN-1:0]     rdata2;

    dispatch u_dispatch (
        .clock         (clock),
        .reset_n       (reset_n),
        .in_valid      (in_valid),
        .in_uop        (in_uop),
        .in_ready      (in_ready),
        .rob_can_enq   (rob_can_enq),
        .alloc_robid   (alloc_robid),
        .rob_enq_valid (rob_enq_valid),
        .rob_enq_entry (rob_enq_entry),
        .iq_can_enq    (iq_can_enq),
        .iq_enq_valid  (iq_enq_valid),
        .iq_enq_entry  (iq_enq_entry),
        .bt_rs1        (bt_rs1),
        .bt_rs2        (bt_rs2),
        .src1_busy     (src1_busy),
        .src2_busy     (src2_busy),
        .bt_alloc_en   (bt_alloc_en),
        .bt_alloc_prd  (bt_alloc_prd)
    );

    rob u_rob (
        .clock         (clock),
        .reset_n       (reset_n),
        .rob_enq_valid (rob_enq_valid),
        .rob_enq_entry (rob_enq_entry),
        .rob_can_enq   (rob_can_enq),
        .alloc_robid   (alloc_robid),
        .wb            (wb),
        .commit        (commit)
    );

    issue_queue u_issue_queue (
        .clock        (clock),
        .reset_n      (reset_n),
        .iq_enq_valid (iq_enq_valid),
        .iq_enq_entry (iq_enq_entry),
        .iq_can_enq   (iq_can_enq),
        .wb           (wb),
        .raddr1       (raddr1),
        .raddr2       (raddr2),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_uop    (issue_uop)
    );

    busy_table u_busy_table (
        .clock        (clock),
        .reset_n      (reset_n),
        .bt_rs1       (bt_rs1),
        .bt_rs2       (bt_rs2),
        .src1_busy    (src1_busy),
        .src2_busy    (src2_busy),
        .bt_alloc_en  (bt_alloc_en),
        .bt_alloc_prd (bt_alloc_prd),
        .wb           (wb)
    );

    preg_file u_preg_file (
        .clock   (clock),
        .reset_n (reset_n),
        .wb      (wb),
        .raddr1  (raddr1),
        .raddr2  (raddr2),
        .rdata1  (rdata1),
        .rdata2  (rdata2)
    );

endmodule

`default_nettype wire

// File: preg_file.sv
`timescale 1ns/1ps
`default_nettype none

module preg_file (
    input  logic                       clock,
    input  logic                       reset_n,
    input  isu_pkg::wb_t               wb,
    input  logic [isu_pkg::PREG_W-1:0] raddr1,
    input  logic [isu_pkg::PREG_W-1:0] raddr2,
    output logic [isu_pkg::XLEN-1:0]   rdata1,
    output logic [isu_pkg::XLEN-1:0]   rdata2
);
    logic [isu_pkg::XLEN-1:0] regs [isu_pkg::PREG_COUNT];

    // single write port from the integer writeback
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < isu_pkg::PREG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.need_to_wb) begin
            regs[wb.prd] <= wb.result;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// File: rob.sv
`timescale 1ns/1ps
`default_nettype none

module rob (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         rob_enq_valid,
    input  isu_pkg::rob_entry_t          rob_enq_entry,
    output logic                         rob_can_enq,
    output logic [isu_pkg::ROB_ID_W-1:0] alloc_robid,
    input  isu_pkg::wb_t                 wb,
    output isu_pkg::commit_t             commit
);
    isu_pkg::rob_entry_t entries [isu_pkg::ROB_DEPTH];
    isu_pkg::rob_entry_t head_entry;

    logic [isu_pkg::ROB_DEPTH-1:0] complete;
    logic [isu_pkg::ROB_ID_W-1:0]  head;
    logic [isu_pkg::ROB_ID_W-1:0]  tail;
    logic [isu_pkg::ROB_IDX_W-1:0] head_idx;
    logic [isu_pkg::ROB_IDX_W-1:0] tail_idx;
    logic [isu_pkg::ROB_IDX_W-1:0] wb_idx;
    logic                          empty;
    logic                          full;
    logic                          enq_fire;
    logic                          commit_fire;

    assign head_idx = head[isu_pkg::ROB_IDX_W-1:0];
    assign tail_idx = tail[isu_pkg::ROB_IDX_W-1:0];
    assign wb_idx   = wb.robid[isu_pkg::ROB_IDX_W-1:0];

    // same index with opposite wrap bits means every entry is taken
    assign empty = (head == tail);
    assign full  = (head_idx == tail_idx) &&
                   (head[isu_pkg::ROB_ID_W-1] != tail[isu_pkg::ROB_ID_W-1]);

    assign rob_can_enq = !full;
    assign alloc_robid = tail;
    assign enq_fire    = rob_enq_valid && rob_can_enq;
    assign commit_fire = !empty && complete[head_idx];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            head     <= '0;
            tail     <= '0;
            complete <= '0;
        end else begin
            if (enq_fire) begin
                tail               <= tail + 1'b1;
                complete[tail_idx] <= 1'b0;
            end
            if (wb.valid) begin
                complete[wb_idx] <= 1'b1;
            end
            if (commit_fire) begin
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enq_fire) begin
            entries[tail_idx] <= rob_enq_entry;
        end
    end

    assign head_entry = entries[head_idx];

    // head retires as soon as it is complete, no back-pressure
    always_comb begin
        commit.valid      = commit_fire;
        commit.robid      = head;
        commit.pc         = head_entry.pc;
        commit.instr      = head_entry.instr;
        commit.lrd        = head_entry.lrd;
        commit.prd        = head_entry.prd;
        commit.old_prd    = head_entry.old_prd;
        commit.need_to_wb = head_entry.need_to_wb;
    end

endmodule

`default_nettype wire

// File: tb_isu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_isu;

    typedef struct packed {
        logic [5:0]  prd;
        logic [5:0]  prs1;
        logic [5:0]  prs2;
        logic        s1;
        logic        s2;
        logic        nwb;
        logic [4:0]  lrd;
        logic [5:0]  old_prd;
        logic [63:0] pc;
        logic [63:0] result;
    } row_t;

    localparam int NUM_ROWS = 44;

    // prd, prs1, prs2, src1/src2 is reg, need_to_wb, lrd, old_prd, pc, result
    row_t rows [16] = '{
        '{6'd1,  6'd40, 6'd41, 1'b1, 1'b0, 1'b1, 5'd1,  6'd33, 64'h1000, 64'h0123_4567_89ab_cdef},
        '{6'd2,  6'd1,  6'd0,  1'b1, 1'b0, 1'b1, 5'd2,  6'd34, 64'h1004, 64'h1111_2222_3333_4444},
        '{6'd3,  6'd1,  6'd2,  1'b1, 1'b1, 1'b1, 5'd3,  6'd35, 64'h1008, 64'hdead_beef_0000_0003},
        '{6'd4,  6'd3,  6'd3,  1'b1, 1'b1, 1'b1, 5'd4,  6'd36, 64'h100c, 64'h0000_0000_0000_0004},
        '{6'd5,  6'd50, 6'd51, 1'b0, 1'b0, 1'b1, 5'd5,  6'd37, 64'h1010, 64'hffff_0000_ffff_0005},
        '{6'd6,  6'd5,  6'd4,  1'b1, 1'b1, 1'b1, 5'd6,  6'd38, 64'h1014, 64'h8000_0000_0000_0006},
        '{6'd7,  6'd6,  6'd2,  1'b1, 1'b1, 1'b0, 5'd0,  6'd39, 64'h1018, 64'h0000_0000_0000_0000},
        '{6'd8,  6'd7,  6'd6,  1'b1, 1'b1, 1'b1, 5'd8,  6'd42, 64'h101c, 64'h5555_aaaa_5555_0008},
        '{6'd9,  6'd8,  6'd1,  1'b1, 1'b1, 1'b1, 5'd9,  6'd43, 64'h1020, 64'h0f0f_0f0f_0f0f_0009},
        '{6'd10, 6'd9,  6'd9,  1'b1, 1'b1, 1'b1, 5'd10, 6'd44, 64'h1024, 64'h1234_0000_0000_000a},
        '{6'd11, 6'd10, 6'd3,  1'b1, 1'b0, 1'b1, 5'd11, 6'd45, 64'h1028, 64'h0000_9999_0000_000b},
        '{6'd12, 6'd11, 6'd10, 1'b1, 1'b1, 1'b1, 5'd12, 6'd46, 64'h102c, 64'hcafe_f00d_0000_000c},
        '{6'd13, 6'd60, 6'd12, 1'b1, 1'b1, 1'b1, 5'd13, 6'd47, 64'h1030, 64'h7777_0000_7777_000d},
        '{6'd14, 6'd13, 6'd13, 1'b1, 1'b1, 1'b1, 5'd14, 6'd48, 64'h1034, 64'h0000_0000_0bad_000e},
        '{6'd15, 6'd2,  6'd14, 1'b1, 1'b1, 1'b1, 5'd15, 6'd49, 64'h1038, 64'h1357_9bdf_2468_000f},
        '{6'd16, 6'd15, 6'd5,  1'b1, 1'b1, 1'b1, 5'd16, 6'd52, 64'h103c, 64'hfedc_ba98_7654_0010}
    };

    logic             clock;
    logic             reset_n;
    logic             in_valid;
    isu_pkg::uop_t    in_uop;
    logic             in_ready;
    logic             issue_valid;
    logic             issue_ready;
    isu_pkg::issue_t  issue_uop;
    isu_pkg::wb_t     wb;
    isu_pkg::commit_t commit;

    isu_pkg::uop_t exp_uop    [64];
    logic [63:0]   exp_result [64];
    logic [63:0]   model      [64];
    logic          pend       [64];
    logic          issued     [64];
    int            seq_of_robid [32];
    int            wb_seq [$];
    int            wb_due [$];
    int            dispatched = 0;
    int            commits = 0;
    int            errors = 0;
    int            cycle = 0;
    logic          hold_issue = 1'b0;
    logic          hold_wb = 1'b0;
    logic [15:0]   lfsr = 16'd30309;

    isu_top i_dut (
        .clock       (clock),
        .reset_n     (reset_n),
        .in_valid    (in_valid),
        .in_uop      (in_uop),
        .in_ready    (in_ready),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_uop   (issue_uop),
        .wb          (wb),
        .commit      (commit)
    );

    always #2 clock = ~clock;

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 16'hb400;
        end
        return b;
    endfunction

    function automatic isu_pkg::uop_t make_uop(input int r, input bit indep, input int k);
        isu_pkg::uop_t u;
        u = '0;
        u.pc          = rows[r].pc;
        u.instr       = 32'h0000_0013 | 32'(k << 12);
        u.lrd         = rows[r].lrd;
        u.prd         = rows[r].prd;
        u.old_prd     = rows[r].old_prd;
        u.need_to_wb  = rows[r].nwb;
        u.prs1        = rows[r].prs1;
        u.prs2        = rows[r].prs2;
        u.src1_is_reg = rows[r].s1 && !indep;
        u.src2_is_reg = rows[r].s2 && !indep;
        u.imm         = 64'(k) * 64'h10;
        u.alu_type    = 11'(k);
        u.is_word     = k[0];
        u.is_unsigned = k[1];
        u.is_imm      = !u.src2_is_reg;
        return u;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic dispatch_row(input int r, input bit indep);
        isu_pkg::uop_t u;
        logic          ready_seen;
        u = make_uop(r, indep, dispatched);
        in_uop     = u;
        in_valid   = 1'b1;
        // in_ready only moves on an edge, so look at it between edges
        ready_seen = in_ready;
        @(posedge clock);
        while (!ready_seen) begin
            #1;
            ready_seen = in_ready;
            @(posedge clock);
        end
        exp_uop[dispatched]    = u;
        exp_result[dispatched] = rows[r].result ^ 64'(dispatched);
        seq_of_robid[dispatched % 32] = dispatched;
        if (u.need_to_wb) begin
            pend[u.prd] = 1'b1;
        end
        dispatched++;
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        wait (commits == dispatched);
        @(posedge clock);
        #1;
    endtask

    // execution unit model with random stalls and writeback delays
    initial begin : exec_unit
        int              k;
        int              idx;
        int              stretch;
        logic            stalled;
        isu_pkg::issue_t held;
        issue_ready = 1'b0;
        wb          = '0;
        stretch     = 0;
        stalled     = 1'b0;
        held        = '0;
        forever begin
            // mid-cycle view of what the next rising edge will take
            @(negedge clock);
            if (reset_n) begin
                cycle++;
                if (stalled && (!issue_valid || (issue_uop !== held))) begin
                    $display("Error at %0t: issue_uop not held while stalled", $time);
                    errors++;
                end
                stalled = issue_valid && !issue_ready;
                held    = issue_uop;
                if (issue_valid && issue_ready) begin
                    k = seq_of_robid[issue_uop.robid];
                    if (issued[k]) begin
                        $display("Error at %0t: micro-op %0d issued twice", $time, k);
                        errors++;
                    end
                    issued[k] = 1'b1;
                    if (issue_uop.uop !== exp_uop[k]) begin
                        $display("Error at %0t: issue_uop.uop expected %h got %h",
                                 $time, exp_uop[k], issue_uop.uop);
                        errors++;
                    end
                    if (exp_uop[k].src1_is_reg && pend[exp_uop[k].prs1]) begin
                        $display("Error at %0t: micro-op %0d issued before src1 written",
                                 $time, k);
                        errors++;
                    end
                    if (exp_uop[k].src2_is_reg && pend[exp_uop[k].prs2]) begin
                        $display("Error at %0t: micro-op %0d issued before src2 written",
                                 $time, k);
                        errors++;
                    end
                    compare_value("issue_uop.src1", issue_uop.src1,
                                  exp_uop[k].src1_is_reg ? model[exp_uop[k].prs1] : 64'h0);
                    compare_value("issue_uop.src2", issue_uop.src2,
                                  exp_uop[k].src2_is_reg ? model[exp_uop[k].prs2] : 64'h0);
                    wb_seq.push_back(k);
                    wb_due.push_back(cycle + 1 + int'({lfsr_bit(), lfsr_bit()}));
                end
                if (wb.valid && wb.need_to_wb) begin
                    model[wb.prd] = wb.result;
                    pend[wb.prd]  = 1'b0;
                end
                @(posedge clock);
                #1;
                wb = '0;
                idx = -1;
                for (int i = 0; i < wb_seq.size(); i++) begin
                    if ((idx < 0) && (wb_due[i] <= cycle)) begin
                        idx = i;
                    end
                end
                if (!hold_wb && (idx >= 0)) begin
                    k = wb_seq[idx];
                    wb_seq.delete(idx);
                    wb_due.delete(idx);
                    wb.valid      = 1'b1;
                    wb.robid      = 5'(k % 32);
                    wb.need_to_wb = exp_uop[k].need_to_wb;
                    wb.prd        = exp_uop[k].prd;
                    wb.result     = exp_result[k];
                end
                if (hold_issue) begin
                    issue_ready = 1'b0;
                    stretch     = 0;
                end else begin
                    if (stretch == 0) begin
                        issue_ready = lfsr_bit() | lfsr_bit();
                        stretch     = 1 + int'({lfsr_bit(), lfsr_bit()});
                    end
                    stretch--;
                end
            end
        end
    end

    // commits must follow dispatch order
    always @(negedge clock) begin
        if (reset_n && commit.valid) begin
            if (commits >= dispatched) begin
                $display("Error at %0t: commit with nothing dispatched", $time);
                errors++;
            end else begin
                compare_value("commit.robid", 64'(commit.robid), 64'(commits % 32));
                compare_value("commit.pc", commit.pc, exp_uop[commits].pc);
                compare_value("commit.instr", 64'(commit.instr), 64'(exp_uop[commits].instr));
                compare_value("commit.lrd", 64'(commit.lrd), 64'(exp_uop[commits].lrd));
                compare_value("commit.prd", 64'(commit.prd), 64'(exp_uop[commits].prd));
                compare_value("commit.old_prd", 64'(commit.old_prd),
                              64'(exp_uop[commits].old_prd));
                compare_value("commit.need_to_wb", 64'(commit.need_to_wb),
                              64'(exp_uop[commits].need_to_wb));
            end
            commits++;
        end
    end

    initial begin : watchdog
        #(NUM_ROWS * 40 * 4 + 5 * 4);
        $display("Error: watchdog timeout with %0d of %0d commits", commits, dispatched);
        $display("Regression failed");
        $finish;
    end

    initial begin
        clock    = 1'b0;
        reset_n  = 1'b0;
        in_valid = 1'b0;
        in_uop   = '0;
        for (int i = 0; i < 64; i++) begin
            model[i]  = '0;
            pend[i]   = 1'b0;
            issued[i] = 1'b0;
        end
        repeat (5) @(posedge clock);
        #1;
        reset_n = 1'b1;
        #1;
        compare_value("in_ready", 64'(in_ready), 64'd1);
        compare_value("issue_valid", 64'(issue_valid), 64'd0);
        compare_value("commit.valid", 64'(commit.valid), 64'd0);
        @(posedge clock);
        #1;

        // dependency chains
        for (int r = 0; r < 16; r++) begin
            dispatch_row(r, 1'b0);
        end
        wait_drain();

        // issue stalled, queue plus issue register fill up
        hold_issue = 1'b1;
        for (int r = 0; r < 9; r++) begin
            dispatch_row(r, 1'b1);
            if (r == 7) begin
                compare_value("in_ready", 64'(in_ready), 64'd1);
            end
        end
        compare_value("in_ready", 64'(in_ready), 64'd0);
        hold_issue = 1'b0;
        dispatch_row(9, 1'b1);
        wait_drain();

        // writebacks held, ROB fills up
        hold_wb = 1'b1;
        for (int r = 0; r < 16; r++) begin
            dispatch_row(r, 1'b1);
        end
        compare_value("in_ready", 64'(in_ready), 64'd0);
        hold_wb = 1'b0;
        dispatch_row(0, 1'b1);
        dispatch_row(1, 1'b1);
        wait_drain();

        for (int k = 0; k < dispatched; k++) begin
            if (!issued[k]) begin
                $display("Error: micro-op %0d was never issued", k);
                errors++;
            end
        end
        $display("dispatched %0d, committed %0d, errors %0d", dispatched, commits, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
